//--- hw/bp_config.svh
/*
  Sizing of the fetch-stage branch predictor.
  Instructions are 2 bytes wide, so PC bit 0 takes no part in index or tag.
  BP_INDEX_BITS sets the depth of both tables at once.
*/
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

////////////////////
// PC layout
////////////////////
`define BP_PC_WIDTH    16                           // One CPU word
`define BP_INSTR_BYTES 2                            // Fall-through step of fetch

////////////////////
// Table geometry
////////////////////
`define BP_INDEX_BITS  3                            // 8 entries per table
`define BP_INDEX_LSB   1                            // Index starts above the byte bit
`define BP_ENTRIES     (1 << `BP_INDEX_BITS)
`define BP_TAG_LSB     (`BP_INDEX_LSB + `BP_INDEX_BITS)
`define BP_TAG_BITS    (`BP_PC_WIDTH - `BP_TAG_LSB) // PC bits above the index

`endif

//--- hw/bp_pkg.sv
/*
  Types shared by the branch predictor blocks.
  Widths come from bp_config.svh.
  The pipeline carries prediction.state to decode and returns it in update.state.
*/
`include "bp_config.svh"

package bp_pkg;

  ////////////////////
  // Counter state
  ////////////////////
  typedef enum logic [1:0] {
    BP_STRONG_NT = 2'd0,                 // Reset value
    BP_WEAK_NT   = 2'd1,
    BP_WEAK_T    = 2'd2,                 // High bit set means predict taken
    BP_STRONG_T  = 2'd3
  } bp_state_t;

  ////////////////////
  // Training from decode
  ////////////////////
  typedef struct packed {
    logic                    valid;      // One-cycle strobe, real branches only
    logic [`BP_PC_WIDTH-1:0] pc;         // PC of the resolved branch
    logic                    taken;      // Actual outcome
    logic [`BP_PC_WIDTH-1:0] target;     // Actual target, even
    bp_state_t               state;      // State that was predicted at fetch
  } bp_update_t;

  ////////////////////
  // Lookup results
  ////////////////////
  typedef struct packed {
    logic                    hit;        // Valid entry with matching tag
    logic [`BP_PC_WIDTH-1:0] target;     // Stored target, don't care on miss
  } bp_btb_result_t;

  typedef struct packed {
    logic                    taken;      // Redirect fetch to next_pc
    logic [`BP_PC_WIDTH-1:0] next_pc;    // Next fetch address
    bp_state_t               state;      // Counter read for this PC
  } bp_prediction_t;

endpackage

//--- hw/bp_history_table.sv
/*
  Branch history table of 2-bit saturating counters.
  The read is combinational. A write lands at the edge after update.valid.
  The new value comes from update.state and never from the stored counter.
  A read in the update cycle still returns the old counter.
*/
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_history_table (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`BP_PC_WIDTH-1:0] fetch_pc,   // PC in fetch
  input  bp_pkg::bp_update_t      update,     // Training word from decode
  output bp_pkg::bp_state_t       read_state  // Counter at fetch_pc's index
);

  ////////////////////
  // Storage
  ////////////////////
  bp_pkg::bp_state_t         counters [`BP_ENTRIES];  // One counter per index
  logic [`BP_INDEX_BITS-1:0] rd_idx;                   // Lookup index
  logic [`BP_INDEX_BITS-1:0] wr_idx;                   // Training index
  bp_pkg::bp_state_t         next_state;               // Saturated training value

  assign rd_idx = fetch_pc[`BP_INDEX_LSB +: `BP_INDEX_BITS];
  assign wr_idx = update.pc[`BP_INDEX_LSB +: `BP_INDEX_BITS];

  // Lookup path, no enable here, bp_select does the gating
  assign read_state = counters[rd_idx];

  ////////////////////
  // Saturating step
  ////////////////////
  always_comb begin
    case (update.state)
      bp_pkg::BP_STRONG_NT: begin
        next_state = update.taken ? bp_pkg::BP_WEAK_NT : bp_pkg::BP_STRONG_NT;  // Floor
      end
      bp_pkg::BP_WEAK_NT: begin
        next_state = update.taken ? bp_pkg::BP_WEAK_T : bp_pkg::BP_STRONG_NT;
      end
      bp_pkg::BP_WEAK_T: begin
        next_state = update.taken ? bp_pkg::BP_STRONG_T : bp_pkg::BP_WEAK_NT;
      end
      bp_pkg::BP_STRONG_T: begin
        next_state = update.taken ? bp_pkg::BP_STRONG_T : bp_pkg::BP_WEAK_T;    // Ceiling
      end
      default: begin
        next_state = bp_pkg::BP_STRONG_NT;   // Unknown state falls back to not taken
      end
    endcase
  end

  ////////////////////
  // Training write
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      counters <= '{default: bp_pkg::BP_STRONG_NT};  // All strongly not taken
    end else if (update.valid) begin
      counters[wr_idx] <= next_state;                // Old value still seen this cycle
    end
  end

  ////////////////////
  // Checks
  ////////////////////
  // Decode must hand back a clean PC and the state carried from fetch
  a_update_known: assert property (
    @(posedge clk) disable iff (rst)
    update.valid |-> !$isunknown({update.pc, update.state})
  ) else $error("bp_history_table: unknown pc or state on a valid update");

endmodule

//--- hw/bp_target_buffer.sv
/*
  Tagged branch target buffer, direct mapped on the same index as the counters.
  Hit check is combinational and a fill lands at the edge after the update.
  Only taken updates fill. Not-taken branches never evict an entry.
  Reset clears the valid bits only, so tag and target are unknown until filled.
*/
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_target_buffer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`BP_PC_WIDTH-1:0] fetch_pc,    // PC in fetch
  input  bp_pkg::bp_update_t      update,      // Training word from decode
  output bp_pkg::bp_btb_result_t  btb_result   // Hit and stored target
);

  ////////////////////
  // Storage
  ////////////////////
  logic [`BP_ENTRIES-1:0]    valid_bits;                  // Entry holds a taken branch
  logic [`BP_TAG_BITS-1:0]   tag_mem    [`BP_ENTRIES];    // PC bits above the index
  logic [`BP_PC_WIDTH-1:0]   target_mem [`BP_ENTRIES];    // Last taken target

  logic [`BP_INDEX_BITS-1:0] rd_idx;
  logic [`BP_TAG_BITS-1:0]   rd_tag;
  logic [`BP_INDEX_BITS-1:0] wr_idx;
  logic [`BP_TAG_BITS-1:0]   wr_tag;
  logic                      fill;                        // Taken training this cycle

  assign rd_idx = fetch_pc[`BP_INDEX_LSB +: `BP_INDEX_BITS];
  assign rd_tag = fetch_pc[`BP_PC_WIDTH-1:`BP_TAG_LSB];
  assign wr_idx = update.pc[`BP_INDEX_LSB +: `BP_INDEX_BITS];
  assign wr_tag = update.pc[`BP_PC_WIDTH-1:`BP_TAG_LSB];
  assign fill   = update.valid && update.taken;

  ////////////////////
  // Lookup
  ////////////////////
  // Aliased PCs share an index and are told apart by the tag
  assign btb_result.hit    = valid_bits[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign btb_result.target = target_mem[rd_idx];   // Meaningful only on hit

  ////////////////////
  // Valid bits
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_bits <= '0;               // Every entry empty
    end else if (fill) begin
      valid_bits[wr_idx] <= 1'b1;     // Stays set, later fills just overwrite
    end
  end

  ////////////////////
  // Tag and target
  ////////////////////
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_mem[wr_idx]    <= wr_tag;
      target_mem[wr_idx] <= update.target;
    end
  end

  ////////////////////
  // Checks
  ////////////////////
  // A stored odd target would send fetch into the middle of an instruction
  a_even_target: assert property (
    @(posedge clk) disable iff (rst)
    fill |-> (update.target[0] == 1'b0)
  ) else $error("bp_target_buffer: taken update with odd target %h", update.target);

endmodule

//--- hw/bp_select.sv
/*
  Fetch redirect decision, purely combinational.
  Taken needs enable, a counter in a taken state and a buffer hit.
  With enable low the output is plain fall-through with state 0.
  clk is used only by the check below.
*/
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_select (
  input  logic                    clk,         // Check clock only
  input  logic                    enable,      // Level from the CPU
  input  logic [`BP_PC_WIDTH-1:0] fetch_pc,
  input  bp_pkg::bp_state_t       read_state,  // From the history table
  input  bp_pkg::bp_btb_result_t  btb_result,  // From the target buffer
  output bp_pkg::bp_prediction_t  prediction
);

  logic                    dir_taken;   // Counter says taken
  logic                    taken;       // Final redirect decision
  logic [`BP_PC_WIDTH-1:0] fall_pc;     // Sequential fetch address

  assign dir_taken = read_state[1];     // Weak or strong taken
  assign taken     = enable && dir_taken && btb_result.hit;
  assign fall_pc   = fetch_pc + `BP_PC_WIDTH'(`BP_INSTR_BYTES);

  ////////////////////
  // Prediction word
  ////////////////////
  assign prediction.taken   = taken;
  assign prediction.next_pc = taken ? btb_result.target : fall_pc;
  // Gated state keeps decode from training on a stale value while disabled
  assign prediction.state   = enable ? read_state : bp_pkg::BP_STRONG_NT;

  ////////////////////
  // Checks
  ////////////////////
  // Holds across fall-through and the buffer's stored target alike
  a_even_next_pc: assert property (
    @(posedge clk)
    !$isunknown(fetch_pc) |-> (prediction.next_pc[0] == 1'b0)
  ) else $error("bp_select: odd next_pc %h", prediction.next_pc);

endmodule

//--- hw/branch_predictor.sv
/*
  Dynamic branch predictor for the fetch stage.
  fetch_pc to prediction is combinational, training shows one cycle later.
  update.valid is a one-cycle strobe, at most one per cycle, never stalled.
*/
`timescale 1ns/1ps
`include "bp_config.svh"

module branch_predictor (
  input  logic                    clk,
  input  logic                    rst,         // Synchronous, active high
  input  logic                    enable,      // Gates the prediction only
  input  logic [`BP_PC_WIDTH-1:0] fetch_pc,
  input  bp_pkg::bp_update_t      update,      // From decode
  output bp_pkg::bp_prediction_t  prediction   // To fetch
);

  bp_pkg::bp_state_t      read_state;          // Counter at fetch_pc
  bp_pkg::bp_btb_result_t btb_result;          // Buffer lookup at fetch_pc

  ////////////////////
  // Tables
  ////////////////////
  bp_history_table i_history (
    .clk        (clk),
    .rst        (rst),
    .fetch_pc   (fetch_pc),
    .update     (update),
    .read_state (read_state)
  );

  bp_target_buffer i_btb (
    .clk        (clk),
    .rst        (rst),
    .fetch_pc   (fetch_pc),
    .update     (update),
    .btb_result (btb_result)
  );

  ////////////////////
  // Decision
  ////////////////////
  bp_select i_select (
    .clk        (clk),
    .enable     (enable),
    .fetch_pc   (fetch_pc),
    .read_state (read_state),
    .btb_result (btb_result),
    .prediction (prediction)
  );

endmodule

//--- testbench/tb_checks.svh
/*
  Compare tasks for the branch predictor testbench, included inside the top module.
  They rely on report_failure of the including module.
*/
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////
// Prediction word
////////////////////
task automatic compare_prediction(
  input string                  name,
  input bp_pkg::bp_prediction_t actual,
  input bp_pkg::bp_prediction_t expected
);
  if (actual !== expected) begin
    report_failure($sformatf("MISMATCH %s actual=%h expected=%h (taken %h next_pc %h state %h)",
                             name, actual, expected,
                             actual.taken, actual.next_pc, actual.state));
  end
endtask

////////////////////
// Counter state
////////////////////
task automatic compare_state(
  input string             name,
  input bp_pkg::bp_state_t actual,
  input bp_pkg::bp_state_t expected
);
  if (actual !== expected) begin
    report_failure($sformatf("MISMATCH %s actual=%h expected=%h", name, actual, expected));
  end
endtask

`endif

//--- testbench/tb_branch_predictor.sv
/*
  Directed and random tests of the fetch-stage branch predictor.
  Outputs are sampled at the falling edge, inputs change on the rising edge.
  The reference model runs in lookup-then-train order, so same-cycle reads see old data.
*/
`timescale 1ns/1ps
`include "bp_config.svh"

module tb_branch_predictor;

  localparam int clk_period  = 40;
  localparam int test_cycles = 4 + 16 + 18 + 9 + 5 + 2 + 200;  // Reset plus each test
  localparam int margin      = 50;

  logic                    clk;
  logic                    rst;
  logic                    enable;
  logic [`BP_PC_WIDTH-1:0] fetch_pc;
  bp_pkg::bp_update_t      update;
  bp_pkg::bp_prediction_t  prediction;

  integer                  seed = 32'h339e_a095;

  // Reference model of both tables
  bp_pkg::bp_state_t       model_state  [`BP_ENTRIES];
  logic                    model_valid  [`BP_ENTRIES];
  logic [`BP_TAG_BITS-1:0] model_tag    [`BP_ENTRIES];
  logic [`BP_PC_WIDTH-1:0] model_target [`BP_ENTRIES];

  branch_predictor i_dut (
    .clk        (clk),
    .rst        (rst),
    .enable     (enable),
    .fetch_pc   (fetch_pc),
    .update     (update),
    .prediction (prediction)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  `include "tb_checks.svh"

  ////////////////////
  // Reference model
  ////////////////////
  function automatic bp_pkg::bp_state_t saturate(bp_pkg::bp_state_t s, logic taken);
    int v;
    v = int'(s) + (taken ? 1 : -1);    // Step toward the outcome
    if (v > 3) v = 3;
    if (v < 0) v = 0;
    return bp_pkg::bp_state_t'(v);
  endfunction

  function automatic bp_pkg::bp_prediction_t model_predict(logic en, logic [15:0] pc);
    bp_pkg::bp_prediction_t p;
    int idx;
    logic hit;
    idx = pc[`BP_INDEX_LSB +: `BP_INDEX_BITS];
    hit = model_valid[idx] && (model_tag[idx] == pc[`BP_PC_WIDTH-1:`BP_TAG_LSB]);
    p.taken   = en && model_state[idx][1] && hit;
    p.next_pc = p.taken ? model_target[idx] : pc + 16'd2;
    p.state   = en ? model_state[idx] : bp_pkg::BP_STRONG_NT;  // Gated while disabled
    return p;
  endfunction

  function automatic void model_apply(bp_pkg::bp_update_t upd);
    int idx;
    idx = upd.pc[`BP_INDEX_LSB +: `BP_INDEX_BITS];
    if (upd.valid) begin
      model_state[idx] = saturate(upd.state, upd.taken);  // From returned state
      if (upd.taken) begin
        model_valid[idx]  = 1'b1;
        model_tag[idx]    = upd.pc[`BP_PC_WIDTH-1:`BP_TAG_LSB];
        model_target[idx] = upd.target;
      end
    end
  endfunction

  function automatic bp_pkg::bp_update_t make_update(logic [15:0] pc, logic taken,
                                                     logic [15:0] target,
                                                     bp_pkg::bp_state_t state);
    bp_pkg::bp_update_t u;
    u.valid  = 1'b1;
    u.pc     = pc;
    u.taken  = taken;
    u.target = target;
    u.state  = state;
    return u;
  endfunction

  ////////////////////
  // Stimulus steps
  ////////////////////
  // One fetch cycle, checked at the falling edge, then the model trains
  task automatic step(input logic en, input logic [15:0] pc, input bp_pkg::bp_update_t upd);
    bp_pkg::bp_prediction_t expected;
    @(posedge clk);
    enable   <= en;
    fetch_pc <= pc;
    update   <= upd;
    @(negedge clk);
    expected = model_predict(en, pc);
    compare_prediction("prediction", prediction, expected);
    model_apply(upd);
  endtask

  task automatic train(input logic [15:0] pc, input logic taken, input logic [15:0] target);
    step(1'b1, pc, '0);                            // Lookup gives the state to return
    step(1'b1, pc, make_update(pc, taken, target,
                               model_state[pc[`BP_INDEX_LSB +: `BP_INDEX_BITS]]));
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic reset_defaults();
    for (int i = 0; i < 8; i++) begin
      step(1'b1, 16'(i * 2), '0);                   // Every index, tag 0
      step(1'b1, 16'h8000 + 16'(i * 2), '0);        // Every index, high tag
    end
  endtask

  task automatic counter_training();
    repeat (4) train(16'h0104, 1'b1, 16'h0400);    // 0 up to 3, then saturate
    step(1'b1, 16'h0104, '0);
    compare_state("saturated high", prediction.state, bp_pkg::BP_STRONG_T);
    repeat (4) train(16'h0104, 1'b0, 16'h0400);    // Back down to 0, then saturate
    step(1'b1, 16'h0104, '0);
    compare_state("saturated low", prediction.state, bp_pkg::BP_STRONG_NT);
  endtask

  task automatic tag_aliasing();
    repeat (3) train(16'h0204, 1'b1, 16'h0600);    // Index 2 strong taken, tag 0x020
    step(1'b1, 16'h0904, '0);                      // Same index, other tag, must miss
    step(1'b1, 16'h0010, make_update(16'h0010, 1'b0, 16'h0800, bp_pkg::BP_STRONG_T));
    step(1'b1, 16'h0010, '0);                      // Counter high but no entry
  endtask

  task automatic enable_low();
    step(1'b0, 16'h0204, '0);                      // Trained entry gated off
    step(1'b0, 16'h0a0c, make_update(16'h0a0c, 1'b1, 16'h0a20, bp_pkg::BP_STRONG_T));
    step(1'b0, 16'h0a0c, '0);
    step(1'b1, 16'h0a0c, '0);                      // Entry trained while disabled
    step(1'b1, 16'h0204, '0);
  endtask

  task automatic same_cycle();
    step(1'b1, 16'h0c0e, make_update(16'h0c0e, 1'b1, 16'h0c40, bp_pkg::BP_WEAK_T));
    step(1'b1, 16'h0c0e, '0);                      // New entry one cycle later
  endtask

  task automatic random_stream();
    bp_pkg::bp_update_t upd;
    logic [15:0]        pc;
    logic               en;
    int                 i;
    for (i = 0; i < 200; i++) begin
      en         = ($random(seed) & 3) != 0;       // Mostly enabled
      pc         = 16'($random(seed)) & 16'h003e;  // Few tags so hits happen
      upd.valid  = 1'($random(seed));
      upd.pc     = 16'($random(seed)) & 16'h003e;
      upd.taken  = 1'($random(seed));
      upd.target = 16'($random(seed)) & 16'hfffe;  // Even targets only
      upd.state  = bp_pkg::bp_state_t'(2'($random(seed)));
      step(en, pc, upd);
    end
  endtask

  ////////////////////
  // Clock, watchdog, sequence
  ////////////////////
  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(clk_period * (test_cycles + margin));
    report_failure("Timeout, the tests did not finish in time");
  end

  initial begin
    rst      = 1'b1;
    enable   = 1'b0;
    fetch_pc = '0;
    update   = '0;
    for (int k = 0; k < `BP_ENTRIES; k++) begin
      model_state[k] = bp_pkg::BP_STRONG_NT;
      model_valid[k] = 1'b0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    reset_defaults();
    counter_training();
    tag_aliasing();
    enable_low();
    same_cycle();
    random_stream();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- tb.f
+incdir+hw
+incdir+testbench
hw/bp_pkg.sv
hw/bp_history_table.sv
hw/bp_target_buffer.sv
hw/bp_select.sv
hw/branch_predictor.sv
testbench/tb_branch_predictor.sv

//--- Bender.yml
package:
  name: branch_predictor

sources:
  - include_dirs:
      - hw
    files:
      - hw/bp_pkg.sv
      - hw/bp_history_table.sv
      - hw/bp_target_buffer.sv
      - hw/bp_select.sv
      - hw/branch_predictor.sv

  - target: test
    include_dirs:
      - hw
      - testbench
    files:
      - testbench/tb_branch_predictor.sv
